// ==== build.f ====
rv_pkg.sv
inst_buffer.sv
decode.sv
reg_file.sv
execute.sv
writeback.sv
int_core_top.sv
int_core_checker.sv
tb_int_core.sv

// ==== Bender.yml ====
package:
  name: int_core

sources:
  - rv_pkg.sv
  - inst_buffer.sv
  - decode.sv
  - reg_file.sv
  - execute.sv
  - writeback.sv
  - int_core_top.sv
  - target: test
    files:
      - int_core_checker.sv
      - tb_int_core.sv

// ==== tb_int_core.sv ====
// Testbench for the RV32I integer datapath
// Random program after a directed prologue, checked against an in-order reference model
`timescale 1ns/1ps
`default_nettype none

module tb_int_core;
    localparam int NUM = 400;

    logic            sink = 1'b0;
    logic            rst = 1'b1;
    rv_pkg::fetch_t  in_data = '0;
    logic            in_valid = 1'b0;
    logic            in_ready;
    rv_pkg::result_t out_data;
    logic            out_valid;
    logic            out_ready = 1'b1;

    logic [31:0]    rng = 32'd78;
    logic [31:0]    prog [NUM];
    logic [31:0]    mreg [32];
    rv_pkg::fetch_t pending [$];
    int             cycle = 0;
    int             idx = 0;
    int             retired = 0;
    int             mismatches = 0;
    int             other_errors = 0;
    int             t_first_in = -1;
    logic           in_fire = 1'b0;
    logic           timed_out = 1'b0;

    int_core_top #(.INBUF_DEPTH(2)) dut0 (.*);

    bind int_core_top int_core_checker chk0 (.*);

    always #20 sink = ~sink;

    always @(posedge sink)
        cycle <= cycle + 1;

    function logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // Registers limited to x0..x7 so dependencies are close together
    function automatic logic [31:0] make_inst();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [6:0]  f7;
        r   = next_rand();
        rd  = {2'b0, r[2:0]};
        rs1 = {2'b0, r[5:3]};
        rs2 = {2'b0, r[8:6]};
        f3  = r[11:9];
        imm = r[31:20];
        f7  = 7'h00;
        case (next_rand() % 10)
            0, 1: begin
                if ((f3 == 3'd0 || f3 == 3'd5) && r[12])
                    f7 = 7'h20;
                return enc_r(f7, rs2, rs1, f3, rd, 7'h33);
            end
            2, 3: begin
                if (f3 == 3'd1)
                    imm[11:5] = 7'h00;
                if (f3 == 3'd5)
                    imm[11:5] = r[12] ? 7'h20 : 7'h00;
                return enc_i(imm, rs1, f3, rd, 7'h13);
            end
            4: return {r[31:12], rd, r[13] ? 7'h37 : 7'h17};
            5: return {r[31:12], rd, 7'h6f};
            6: return enc_i(imm, rs1, 3'd0, rd, 7'h67);
            // funct3 2 and 3 give illegal branches now and then
            7: return {imm[11:5], rs2, rs1, f3, r[19:15], 7'h63};
            8: return {imm[11:5], rs2, rs1, f3, rd, r[13] ? 7'h03 : 7'h23};
            default: return enc_i(imm, rs1, f3, rd, 7'h0b);
        endcase
    endfunction

    // RV32I rules applied to the model state
    function automatic rv_pkg::result_t expect_result(rv_pkg::fetch_t f);
        logic [31:0]     ir;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     imm_i;
        logic [31:0]     imm_b;
        logic [31:0]     imm_j;
        logic [2:0]      f3;
        logic            alt;
        logic            tk;
        rv_pkg::result_t r;
        ir    = f.ir;
        f3    = ir[14:12];
        alt   = ir[30];
        a     = mreg[ir[19:15]];
        b     = mreg[ir[24:20]];
        imm_i = {{20{ir[31]}}, ir[31:20]};
        imm_b = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
        imm_j = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
        tk    = 1'b0;
        r     = '0;
        r.pc  = f.pc;
        r.rd  = ir[11:7];
        case (ir[6:0])
            7'h33, 7'h13: begin
                if (ir[6:0] == 7'h13)
                    b = imm_i;
                r.wr_en = 1'b1;
                case (f3)
                    3'd0: r.result = (ir[6:0] == 7'h33 && alt) ? a - b : a + b;
                    3'd1: r.result = a << b[4:0];
                    3'd2: r.result = {31'b0, $signed(a) < $signed(b)};
                    3'd3: r.result = {31'b0, a < b};
                    3'd4: r.result = a ^ b;
                    3'd5: begin
                        if (alt)
                            r.result = $signed(a) >>> b[4:0];
                        else
                            r.result = a >> b[4:0];
                    end
                    3'd6: r.result = a | b;
                    default: r.result = a & b;
                endcase
            end
            7'h37, 7'h17: begin
                r.wr_en  = 1'b1;
                r.result = {ir[31:12], 12'b0} + ((ir[6:0] == 7'h17) ? f.pc : 32'd0);
            end
            7'h6f, 7'h67: begin
                r.wr_en    = 1'b1;
                r.result   = f.pc + 32'd4;
                r.redirect = 1'b1;
                if (ir[6:0] == 7'h6f)
                    r.target = f.pc + imm_j;
                else
                    r.target = (a + imm_i) & ~32'd1;
            end
            7'h63: begin
                case (f3)
                    3'd0: tk = a == b;
                    3'd1: tk = a != b;
                    3'd4: tk = $signed(a) < $signed(b);
                    3'd5: tk = $signed(a) >= $signed(b);
                    3'd6: tk = a < b;
                    3'd7: tk = a >= b;
                    default: r.illegal = 1'b1;
                endcase
                if (!r.illegal) begin
                    r.redirect = tk;
                    r.target   = f.pc + imm_b;
                end
            end
            default: r.illegal = 1'b1;
        endcase
        return r;
    endfunction

    task automatic check_field(string name, logic [31:0] exp, logic [31:0] got);
        assert (got === exp) else begin
            $display("[FAIL] %s pc=%h expected %h got %h", name, out_data.pc, exp, got);
            mismatches++;
        end
    endtask

    task automatic check_output();
        rv_pkg::fetch_t  f;
        rv_pkg::result_t e;
        if (pending.size() == 0) begin
            $display("Output appeared with no instruction pending");
            other_errors++;
            return;
        end
        f = pending.pop_front();
        e = expect_result(f);
        check_field("pc", e.pc, out_data.pc);
        check_field("rd", 32'(e.rd), 32'(out_data.rd));
        check_field("result", e.result, out_data.result);
        check_field("wr_en", 32'(e.wr_en), 32'(out_data.wr_en));
        check_field("redirect", 32'(e.redirect), 32'(out_data.redirect));
        check_field("target", e.target, out_data.target);
        check_field("illegal", 32'(e.illegal), 32'(out_data.illegal));
        if (!e.illegal && e.wr_en && e.rd != 5'd0)
            mreg[e.rd] = e.result;
        // First item enters an empty pipeline with out_ready high
        if (retired == 0) begin
            assert (cycle - t_first_in == 4) else begin
                $display("[FAIL] latency expected %h got %h", 4, cycle - t_first_in);
                mismatches++;
            end
        end
        retired++;
    endtask

    // Sample between edges where everything is settled
    always @(negedge sink) begin
        in_fire = in_valid && in_ready;
        if (in_fire) begin
            pending.push_back(in_data);
            if (t_first_in < 0)
                t_first_in = cycle;
        end
        if (out_valid && out_ready)
            check_output();
    end

    initial begin
        int idle;
        for (int i = 0; i < 32; i++)
            mreg[i] = 32'd0;
        prog[0] = {20'h80000, 5'd1, 7'h37};
        prog[1] = enc_i(12'hfff, 5'd0, 3'd0, 5'd2, 7'h13);
        prog[2] = enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd3, 7'h33);
        prog[3] = enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd4, 7'h33);
        prog[4] = enc_r(7'h00, 5'd1, 5'd2, 3'd3, 5'd5, 7'h33);
        prog[5] = enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd6, 7'h33);
        // Load into x3, then read x3 back
        prog[6] = enc_i(12'h000, 5'd1, 3'd2, 5'd3, 7'h03);
        prog[7] = enc_r(7'h00, 5'd0, 5'd3, 3'd0, 5'd7, 7'h33);
        for (int i = 8; i < NUM; i++)
            prog[i] = make_inst();

        repeat (16) @(posedge sink);
        rst <= 1'b0;

        idle = 0;
        while (retired < NUM && !timed_out) begin
            @(posedge sink);
            if (in_fire)
                idx++;
            if (idx < NUM) begin
                if (!in_valid || in_fire) begin
                    in_valid <= (idx < 40) ? 1'b1 : (next_rand() % 4 != 0);
                    in_data  <= '{pc: 32'h1000 + 32'(idx) * 4, ir: prog[idx]};
                end
            end else begin
                in_valid <= 1'b0;
            end
            out_ready <= (idx < 40) ? 1'b1 : (next_rand() % 3 != 0);
            if (in_fire || (out_valid && out_ready))
                idle = 0;
            else
                idle++;
            if (idle > 500) begin
                $display("Timeout: no progress after %0d of %0d instructions retired",
                         retired, NUM);
                timed_out = 1'b1;
            end
        end

        $display("Errors: %0d mismatches, %0d other, %0d assertion, %0d timeouts", mismatches,
                 other_errors, dut0.chk0.failures, timed_out);
        if (mismatches == 0 && other_errors == 0 && dut0.chk0.failures == 0 && !timed_out
                && pending.size() == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== int_core_checker.sv ====
// Protocol and reset checks for the integer datapath top level
// Output hold under back-pressure, reset behavior, illegal items
`timescale 1ns/1ps
`default_nettype none

module int_core_checker (
    input logic            sink,
    input logic            rst,
    input logic            in_ready,
    input logic            out_valid,
    input logic            out_ready,
    input rv_pkg::result_t out_data
);
    int failures = 0;

    // Held output must not move until taken
    a_out_hold: assert property (@(posedge sink) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else begin
            $error("out_data changed while stalled");
            failures++;
        end

    // Outputs settle on the first reset edge and hold from then on
    a_rst_quiet: assert property (@(posedge sink)
        rst && $past(rst) && !$isunknown({$past(in_ready), $past(out_valid)})
        |-> $stable(in_ready) && $stable(out_valid))
        else begin
            $error("in_ready or out_valid moved during reset");
            failures++;
        end

    a_rst_exit: assert property (@(posedge sink)
        $fell(rst) |-> !out_valid && in_ready)
        else begin
            $error("outputs not idle after reset");
            failures++;
        end

    // Illegal items never write or redirect
    a_illegal: assert property (@(posedge sink) disable iff (rst)
        out_valid && out_data.illegal |-> !out_data.wr_en && !out_data.redirect)
        else begin
            $error("illegal item carries wr_en or redirect");
            failures++;
        end

endmodule

`default_nettype wire

// ==== int_core_top.sv ====
// RV32I integer datapath top level
// Input buffer, decode, register file, execute and writeback in one pipeline
`timescale 1ns/1ps
`default_nettype none

module int_core_top #(
    parameter int INBUF_DEPTH = 2
) (
    input  logic            sink,
    input  logic            rst,
    input  rv_pkg::fetch_t  in_data,
    input  logic            in_valid,
    output logic            in_ready,
    output rv_pkg::result_t out_data,
    output logic            out_valid,
    input  logic            out_ready
);
    rv_pkg::fetch_t    buf_data;
    logic              buf_valid;
    logic              buf_ready;
    rv_pkg::exec_t     ex_data;
    logic              ex_valid;
    logic              ex_ready;
    rv_pkg::result_t   rs_data;
    logic              rs_valid;
    logic              rs_ready;
    rv_pkg::reg_addr_t rs1_addr;
    rv_pkg::reg_addr_t rs2_addr;
    rv_pkg::word_t     rs1_data;
    rv_pkg::word_t     rs2_data;
    rv_pkg::fwd_t      exe_fwd;
    rv_pkg::fwd_t      wb_fwd;
    logic              wr_en;
    rv_pkg::reg_addr_t wr_addr;
    rv_pkg::word_t     wr_data;

    inst_buffer #(.INBUF_DEPTH(INBUF_DEPTH)) inbuf0 (
        .sink, .rst,
        .in_data, .in_valid, .in_ready,
        .buf_data, .buf_valid, .buf_ready
    );

    decode dec0 (
        .sink, .rst,
        .buf_data, .buf_valid, .buf_ready,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .exe_fwd, .wb_fwd,
        .ex_data, .ex_valid, .ex_ready
    );

    reg_file rf0 (
        .sink, .rst,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .wr_en, .wr_addr, .wr_data
    );

    execute exe0 (
        .sink, .rst,
        .ex_data, .ex_valid, .ex_ready,
        .exe_fwd,
        .rs_data, .rs_valid, .rs_ready
    );

    writeback wb0 (
        .sink, .rst,
        .rs_data, .rs_valid, .rs_ready,
        .wb_fwd, .wr_en, .wr_addr, .wr_data,
        .out_data, .out_valid, .out_ready
    );

endmodule

`default_nettype wire

// ==== writeback.sv ====
// Writeback stage
// Retire register that drives the output stream and commits to the register file
`timescale 1ns/1ps
`default_nettype none

module writeback (
    input  logic              sink,
    input  logic              rst,
    input  rv_pkg::result_t   rs_data,
    input  logic              rs_valid,
    output logic              rs_ready,
    output rv_pkg::fwd_t      wb_fwd,
    output logic              wr_en,
    output rv_pkg::reg_addr_t wr_addr,
    output rv_pkg::word_t     wr_data,
    output rv_pkg::result_t   out_data,
    output logic              out_valid,
    input  logic              out_ready
);
    logic commits;

    assign rs_ready = !out_valid || out_ready;

    always_ff @(posedge sink) begin
        if (rst)
            out_valid <= 1'b0;
        else if (rs_ready)
            out_valid <= rs_valid;
    end

    always_ff @(posedge sink) begin
        if (rs_valid && rs_ready)
            out_data <= rs_data;
    end

    // Held item has a register result
    assign commits = !out_data.illegal && out_data.wr_en && out_data.rd != '0;

    assign wr_en   = out_valid && out_ready && commits;
    assign wr_addr = out_data.rd;
    assign wr_data = out_data.result;

    assign wb_fwd.valid = out_valid && commits;
    assign wb_fwd.rd    = out_data.rd;
    assign wb_fwd.value = out_data.result;

endmodule

`default_nettype wire

// ==== execute.sv ====
// Execute stage
// ALU, branch compare and jump/branch targets on the held item
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  logic            sink,
    input  logic            rst,
    input  rv_pkg::exec_t   ex_data,
    input  logic            ex_valid,
    output logic            ex_ready,
    output rv_pkg::fwd_t    exe_fwd,
    output rv_pkg::result_t rs_data,
    output logic            rs_valid,
    input  logic            rs_ready
);
    rv_pkg::exec_t cur;
    logic          cur_valid;
    rv_pkg::word_t alu;
    logic          taken;

    assign ex_ready = !cur_valid || rs_ready;
    assign rs_valid = cur_valid;

    always_ff @(posedge sink) begin
        if (rst)
            cur_valid <= 1'b0;
        else if (ex_ready)
            cur_valid <= ex_valid;
    end

    always_ff @(posedge sink) begin
        if (ex_valid && ex_ready)
            cur <= ex_data;
    end

    always_comb begin
        case (cur.ctrl.fn)
            rv_pkg::ADD:  alu = cur.op1 + cur.op2;
            rv_pkg::SUB:  alu = cur.op1 - cur.op2;
            rv_pkg::SLL:  alu = cur.op1 << cur.op2[4:0];
            rv_pkg::SLT:  alu = {31'b0, $signed(cur.op1) < $signed(cur.op2)};
            rv_pkg::SLTU: alu = {31'b0, cur.op1 < cur.op2};
            rv_pkg::XOR:  alu = cur.op1 ^ cur.op2;
            rv_pkg::SRL:  alu = cur.op1 >> cur.op2[4:0];
            rv_pkg::SRA:  alu = $unsigned($signed(cur.op1) >>> cur.op2[4:0]);
            rv_pkg::OR:   alu = cur.op1 | cur.op2;
            rv_pkg::AND:  alu = cur.op1 & cur.op2;
            default:      alu = cur.op2;
        endcase
    end

    always_comb begin
        case (cur.ctrl.br)
            rv_pkg::BEQ:  taken = cur.rs1 == cur.rs2;
            rv_pkg::BNE:  taken = cur.rs1 != cur.rs2;
            rv_pkg::BLT:  taken = $signed(cur.rs1) < $signed(cur.rs2);
            rv_pkg::BGE:  taken = $signed(cur.rs1) >= $signed(cur.rs2);
            rv_pkg::BLTU: taken = cur.rs1 < cur.rs2;
            rv_pkg::BGEU: taken = cur.rs1 >= cur.rs2;
            default:      taken = 1'b0;
        endcase
    end

    always_comb begin
        rs_data          = '0;
        rs_data.pc       = cur.pc;
        rs_data.rd       = cur.rd;
        rs_data.illegal  = cur.illegal;
        case (cur.ctrl.kind)
            rv_pkg::INTEGER: begin
                rs_data.result = alu;
                rs_data.wr_en  = 1'b1;
            end
            rv_pkg::JUMP: begin
                rs_data.result   = cur.pc + 32'd4;
                rs_data.wr_en    = 1'b1;
                rs_data.redirect = 1'b1;
                rs_data.target   = {alu[31:1], 1'b0};
            end
            rv_pkg::BRANCH: begin
                rs_data.redirect = taken;
                rs_data.target   = alu;
            end
            default: ;
        endcase
    end

    assign exe_fwd.valid = cur_valid && !cur.illegal && rs_data.wr_en && cur.rd != '0;
    assign exe_fwd.rd    = cur.rd;
    assign exe_fwd.value = rs_data.result;

endmodule

`default_nettype wire

// ==== reg_file.sv ====
// Integer register file
// 32 x 32-bit, two combinational read ports, one write port, x0 tied to zero
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic              sink,
    input  logic              rst,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data,
    input  logic              wr_en,
    input  rv_pkg::reg_addr_t wr_addr,
    input  rv_pkg::word_t     wr_data
);
    rv_pkg::word_t regs [1:31];

    always_ff @(posedge sink) begin
        if (rst) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // x0 never stored
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== decode.sv ====
// Instruction decode stage
// Holds the fetched instruction, decodes it, builds immediates and
// resolves operands from execute, writeback or the register file
`timescale 1ns/1ps
`default_nettype none

module decode (
    input  logic              sink,
    input  logic              rst,
    input  rv_pkg::fetch_t    buf_data,
    input  logic              buf_valid,
    output logic              buf_ready,
    output rv_pkg::reg_addr_t rs1_addr,
    output rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    input  rv_pkg::fwd_t      exe_fwd,
    input  rv_pkg::fwd_t      wb_fwd,
    output rv_pkg::exec_t     ex_data,
    output logic              ex_valid,
    input  logic              ex_ready
);
    rv_pkg::fetch_t   cur;
    logic             cur_valid;
    rv_pkg::inst_t    ir;
    rv_pkg::ctrl_t    ctrl;
    rv_pkg::op1_sel_e op1_sel;
    rv_pkg::op2_sel_e op2_sel;
    rv_pkg::word_t    i_imm;
    rv_pkg::word_t    b_imm;
    rv_pkg::word_t    u_imm;
    rv_pkg::word_t    j_imm;
    rv_pkg::word_t    rs1;
    rv_pkg::word_t    rs2;

    // Newest producer wins
    function automatic rv_pkg::word_t resolve(rv_pkg::reg_addr_t addr, rv_pkg::word_t rf,
                                              rv_pkg::fwd_t exe, rv_pkg::fwd_t wb);
        if (exe.valid && exe.rd == addr)
            return exe.value;
        if (wb.valid && wb.rd == addr)
            return wb.value;
        return rf;
    endfunction

    assign buf_ready = !cur_valid || ex_ready;
    assign ex_valid  = cur_valid;

    always_ff @(posedge sink) begin
        if (rst)
            cur_valid <= 1'b0;
        else if (buf_ready)
            cur_valid <= buf_valid;
    end

    always_ff @(posedge sink) begin
        if (buf_valid && buf_ready)
            cur <= buf_data;
    end

    assign ir       = cur.ir;
    assign rs1_addr = ir.r.rs1;
    assign rs2_addr = ir.r.rs2;

    assign i_imm = {{20{ir.i.imm_11_0[11]}}, ir.i.imm_11_0};
    assign b_imm = {{19{ir.b.imm_12}}, ir.b.imm_12, ir.b.imm_11, ir.b.imm_10_5,
                    ir.b.imm_4_1, 1'b0};
    assign u_imm = {ir.u.imm_31_12, 12'b0};
    assign j_imm = {{11{ir.j.imm_20}}, ir.j.imm_20, ir.j.imm_19_12, ir.j.imm_11,
                    ir.j.imm_10_1, 1'b0};

    always_comb begin
        ctrl    = '{kind: rv_pkg::NONE, fn: rv_pkg::ADD, br: rv_pkg::NA};
        op1_sel = rv_pkg::RS1;
        op2_sel = rv_pkg::RS2;
        case (ir.r.opcode)
            rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM: begin
                ctrl.kind = rv_pkg::INTEGER;
                if (ir.r.opcode == rv_pkg::OPC_OP_IMM)
                    op2_sel = rv_pkg::I_IMM;
                case (ir.r.funct3)
                    3'b000: begin
                        // Immediate form has no SUB
                        if (ir.r.funct7[5] && ir.r.opcode == rv_pkg::OPC_OP)
                            ctrl.fn = rv_pkg::SUB;
                        else
                            ctrl.fn = rv_pkg::ADD;
                    end
                    3'b001: ctrl.fn = rv_pkg::SLL;
                    3'b010: ctrl.fn = rv_pkg::SLT;
                    3'b011: ctrl.fn = rv_pkg::SLTU;
                    3'b100: ctrl.fn = rv_pkg::XOR;
                    3'b101: ctrl.fn = ir.r.funct7[5] ? rv_pkg::SRA : rv_pkg::SRL;
                    3'b110: ctrl.fn = rv_pkg::OR;
                    default: ctrl.fn = rv_pkg::AND;
                endcase
            end
            rv_pkg::OPC_LUI: begin
                ctrl.kind = rv_pkg::INTEGER;
                ctrl.fn   = rv_pkg::PASS_OP2;
                op2_sel   = rv_pkg::U_IMM;
            end
            rv_pkg::OPC_AUIPC: begin
                ctrl.kind = rv_pkg::INTEGER;
                op1_sel   = rv_pkg::PC;
                op2_sel   = rv_pkg::U_IMM;
            end
            rv_pkg::OPC_JAL: begin
                ctrl.kind = rv_pkg::JUMP;
                op1_sel   = rv_pkg::PC;
                op2_sel   = rv_pkg::J_IMM;
            end
            rv_pkg::OPC_JALR: begin
                ctrl.kind = rv_pkg::JUMP;
                op2_sel   = rv_pkg::I_IMM;
            end
            rv_pkg::OPC_BRANCH: begin
                ctrl.kind = rv_pkg::BRANCH;
                op1_sel   = rv_pkg::PC;
                op2_sel   = rv_pkg::B_IMM;
                case (ir.r.funct3)
                    3'b000: ctrl.br = rv_pkg::BEQ;
                    3'b001: ctrl.br = rv_pkg::BNE;
                    3'b100: ctrl.br = rv_pkg::BLT;
                    3'b101: ctrl.br = rv_pkg::BGE;
                    3'b110: ctrl.br = rv_pkg::BLTU;
                    3'b111: ctrl.br = rv_pkg::BGEU;
                    default: ctrl.kind = rv_pkg::NONE;
                endcase
            end
            default: ctrl.kind = rv_pkg::NONE;
        endcase
    end

    assign rs1 = resolve(rs1_addr, rs1_data, exe_fwd, wb_fwd);
    assign rs2 = resolve(rs2_addr, rs2_data, exe_fwd, wb_fwd);

    always_comb begin
        ex_data.ctrl    = ctrl;
        ex_data.pc      = cur.pc;
        ex_data.op1     = (op1_sel == rv_pkg::PC) ? cur.pc : rs1;
        ex_data.rs1     = rs1;
        ex_data.rs2     = rs2;
        ex_data.rd      = ir.r.rd;
        ex_data.illegal = ctrl.kind == rv_pkg::NONE;
        case (op2_sel)
            rv_pkg::I_IMM: ex_data.op2 = i_imm;
            rv_pkg::B_IMM: ex_data.op2 = b_imm;
            rv_pkg::U_IMM: ex_data.op2 = u_imm;
            rv_pkg::J_IMM: ex_data.op2 = j_imm;
            default:       ex_data.op2 = rs2;
        endcase
    end

endmodule

`default_nettype wire

// ==== inst_buffer.sv ====
// Instruction input buffer
// Circular FIFO between the instruction source and decode
`timescale 1ns/1ps
`default_nettype none

module inst_buffer #(
    parameter int INBUF_DEPTH = 2
) (
    input  logic           sink,
    input  logic           rst,
    input  rv_pkg::fetch_t in_data,
    input  logic           in_valid,
    output logic           in_ready,
    output rv_pkg::fetch_t buf_data,
    output logic           buf_valid,
    input  logic           buf_ready
);
    localparam int PTR_W = $clog2(INBUF_DEPTH);

    rv_pkg::fetch_t   mem [INBUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    assign in_ready  = count != (PTR_W + 1)'(INBUF_DEPTH);
    assign buf_valid = count != '0;
    assign buf_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = buf_valid && buf_ready;

    always_ff @(posedge sink) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap naturally at a power-of-two depth
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge sink) begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

endmodule

`default_nettype wire

// ==== rv_pkg.sv ====
// RV32I integer datapath package
// Word, instruction and control types, decode enums and the stream payloads
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Instruction field views
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } inst_t;

    // Major opcodes handled by this datapath
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [1:0] {NONE, INTEGER, JUMP, BRANCH} op_kind_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_OP2
    } alu_fn_e;

    typedef enum logic [2:0] {NA, BEQ, BNE, BLT, BGE, BLTU, BGEU} branch_e;

    typedef enum logic {RS1, PC} op1_sel_e;

    typedef enum logic [2:0] {RS2, I_IMM, B_IMM, U_IMM, J_IMM} op2_sel_e;

    typedef struct packed {
        op_kind_e kind;
        alu_fn_e  fn;
        branch_e  br;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        inst_t ir;
    } fetch_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc;
        word_t     op1;
        word_t     op2;
        word_t     rs1;
        word_t     rs2;
        reg_addr_t rd;
        logic      illegal;
    } exec_t;

    typedef struct packed {
        word_t     pc;
        reg_addr_t rd;
        word_t     result;
        logic      wr_en;
        logic      redirect;
        word_t     target;
        logic      illegal;
    } result_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     value;
    } fwd_t;

endpackage

`default_nettype wire
